// ==== hw/ifu_pkg.sv ====
package ifu_pkg;

    // byte address and memory beat
    typedef logic [63:0] addr_t;
    typedef logic [63:0] beat_t;

    // instruction word as seen by decode
    typedef logic [31:0] inst_t;

    // one 16-bit parcel
    typedef logic [15:0] half_t;

    // halfword position of the pc inside a beat
    typedef enum logic [1:0] {
        lane0 = 2'd0,
        lane1 = 2'd1,
        lane2 = 2'd2,
        lane3 = 2'd3
    } lane_t;

    // bytes fetched per read address
    localparam int BEAT_BYTES = 8;

    // low bits of a full-length instruction
    localparam logic [1:0] LEN32_MARK = 2'd3;

endpackage

// ==== hw/inst_if.sv ====
interface inst_if import ifu_pkg::*; ();

    logic  valid;
    logic  ready;
    inst_t inst;
    addr_t pc;
    logic  compressed;

    // producer side, valid is raised without looking at ready
    modport aligner (
        output valid,
        output inst,
        output pc,
        output compressed,
        input  ready
    );

    modport buffer (
        input  valid,
        input  inst,
        input  pc,
        input  compressed,
        output ready
    );

endinterface

// ==== hw/fetch_request.sv ====
module fetch_request import ifu_pkg::*; #(
    parameter addr_t RST_PC          = '0,
    parameter int    FIFO_DEPTH      = 4,
    parameter int    MAX_OUTSTANDING = 4
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  redirect_valid,
    input  addr_t redirect_pc,
    input  logic  arready,
    input  logic  rvalid,
    input  beat_t rdata,
    input  logic  pop,
    output logic  arvalid,
    output addr_t araddr,
    output logic  push,
    output beat_t beat
);

    localparam int CRD_W = $clog2(FIFO_DEPTH + 1);
    localparam int OUT_W = $clog2(MAX_OUTSTANDING + 1);

    addr_t            pc_q;
    logic [CRD_W-1:0] credit_q;
    logic [CRD_W-1:0] credit_d;
    logic [OUT_W-1:0] out_q;
    logic [OUT_W-1:0] out_d;
    logic [OUT_W-1:0] discard_q;
    logic             arvalid_q;
    logic             ar_fire;

    assign ar_fire = arvalid_q && arready;
    assign arvalid = arvalid_q;
    assign araddr  = {pc_q[63:3], 3'b000};

    // beats for addresses issued before a redirect are dropped here
    assign push = rvalid && (discard_q == '0);
    assign beat = rdata;

    // one credit per free queue slot
    always_comb begin
        credit_d = credit_q;
        if (ar_fire && !pop) begin
            credit_d = credit_q - CRD_W'(1);
        end else if (!ar_fire && pop) begin
            credit_d = credit_q + CRD_W'(1);
        end
    end

    // addresses accepted but not answered yet
    always_comb begin
        out_d = out_q;
        if (ar_fire && !rvalid) begin
            out_d = out_q + OUT_W'(1);
        end else if (!ar_fire && rvalid) begin
            out_d = out_q - OUT_W'(1);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q      <= RST_PC;
            credit_q  <= CRD_W'(FIFO_DEPTH);
            out_q     <= '0;
            discard_q <= '0;
            arvalid_q <= 1'b0;
        end else if (redirect_valid) begin
            pc_q      <= redirect_pc;
            credit_q  <= CRD_W'(FIFO_DEPTH);
            out_q     <= out_d;
            // everything still unanswered belongs to the old stream
            discard_q <= out_d;
            arvalid_q <= 1'b0;
        end else begin
            if (ar_fire) begin
                pc_q <= araddr + addr_t'(BEAT_BYTES);
            end
            credit_q <= credit_d;
            out_q    <= out_d;
            if (rvalid && (discard_q != '0)) begin
                discard_q <= discard_q - OUT_W'(1);
            end
            // a stalled request keeps both limits satisfied, so it stays up
            arvalid_q <= (credit_d != '0) && (out_d < OUT_W'(MAX_OUTSTANDING));
        end
    end

endmodule

// ==== hw/beat_fifo.sv ====
module beat_fifo import ifu_pkg::*; #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  redirect_valid,
    input  logic  push,
    input  beat_t beat,
    input  logic  pop,
    output beat_t head,
    output logic  empty
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    beat_t            mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    assign head  = mem[rd_ptr];
    assign empty = (count == '0);

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= beat;
        end
    end

    // pointers wrap at the depth, which need not be a power of two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (redirect_valid) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
            end
            if (push && !pop) begin
                count <= count + CNT_W'(1);
            end else if (pop && !push) begin
                count <= count - CNT_W'(1);
            end
        end
    end

endmodule

// ==== hw/inst_aligner.sv ====
module inst_aligner import ifu_pkg::*; #(
    parameter addr_t RST_PC = '0
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  redirect_valid,
    input  addr_t redirect_pc,
    input  beat_t head,
    input  logic  empty,
    output logic  pop,
    inst_if.aligner out
);

    addr_t      pc_q;
    half_t      carry_q;
    logic       carry_valid_q;
    lane_t      lane;
    inst_t      window;
    logic       is32;
    logic       fill;
    logic       fire;
    logic       ends_beat;
    logic [2:0] next_pos;

    assign lane = lane_t'(pc_q[2:1]);

    // 32-bit window starting at the pc halfword
    always_comb begin
        case (lane)
            lane0:   window = head[31:0];
            lane1:   window = head[47:16];
            lane2:   window = head[63:32];
            default: window = {head[15:0], carry_q};
        endcase
    end

    assign is32 = (window[1:0] == LEN32_MARK);

    // halfword index of the next pc, relative to this beat
    assign next_pos  = {1'b0, pc_q[2:1]} + (is32 ? 3'd2 : 3'd1);
    // in lane3 the beat holding the low half was already popped
    assign ends_beat = (lane != lane3) && (next_pos >= 3'd3);

    // first beat after a jump into lane3 only primes the carry
    assign fill = (lane == lane3) && !carry_valid_q && !empty;

    always_comb begin
        if (lane == lane3) begin
            // a compressed op here lives entirely in the carry
            out.valid = carry_valid_q && (!is32 || !empty);
        end else begin
            out.valid = !empty;
        end
    end

    assign out.inst       = is32 ? window : {half_t'(0), window[15:0]};
    assign out.pc         = pc_q;
    assign out.compressed = !is32;

    assign fire = out.valid && out.ready;
    assign pop  = fill || (fire && ends_beat);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q          <= RST_PC;
            carry_valid_q <= 1'b0;
        end else if (redirect_valid) begin
            pc_q          <= redirect_pc;
            carry_valid_q <= 1'b0;
        end else begin
            if (fire) begin
                pc_q <= pc_q + (is32 ? addr_t'(4) : addr_t'(2));
            end
            if (pop) begin
                carry_valid_q <= 1'b1;
            end
        end
    end

    // upper parcel of the beat leaving the queue
    always_ff @(posedge clk) begin
        if (pop) begin
            carry_q <= head[63:48];
        end
    end

endmodule

// ==== hw/decode_buffer.sv ====
module decode_buffer import ifu_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  redirect_valid,
    inst_if.buffer in,
    input  logic  inst_ready,
    output logic  inst_valid,
    output inst_t inst,
    output addr_t inst_pc,
    output logic  inst_compressed
);

    logic [1:0] ent_valid;
    inst_t      ent_inst [2];
    addr_t      ent_pc [2];
    logic       ent_comp [2];
    logic       sel_q;
    logic       wr_sel;
    logic       load;
    logic       out_fire;

    // entry shown to decode
    assign inst_valid      = ent_valid[sel_q];
    assign inst            = ent_inst[sel_q];
    assign inst_pc         = ent_pc[sel_q];
    assign inst_compressed = ent_comp[sel_q];

    assign in.ready = !(ent_valid[0] && ent_valid[1]);
    assign load     = in.valid && in.ready;
    assign out_fire = inst_valid && inst_ready;

    // fill the visible slot first, then the other one
    assign wr_sel = ent_valid[sel_q] ? !sel_q : sel_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ent_valid <= 2'b00;
            sel_q     <= 1'b0;
        end else if (redirect_valid) begin
            ent_valid <= 2'b00;
            sel_q     <= 1'b0;
        end else begin
            if (out_fire) begin
                ent_valid[sel_q] <= 1'b0;
                sel_q            <= !sel_q;
            end
            // never the slot being drained, see wr_sel
            if (load) begin
                ent_valid[wr_sel] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            ent_inst[wr_sel] <= in.inst;
            ent_pc[wr_sel]   <= in.pc;
            ent_comp[wr_sel] <= in.compressed;
        end
    end

endmodule

// ==== hw/ifu_top.sv ====
module ifu_top #(
    parameter ifu_pkg::addr_t RST_PC          = '0,
    parameter int             FIFO_DEPTH      = 4,
    parameter int             MAX_OUTSTANDING = 4
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           redirect_valid,
    input  ifu_pkg::addr_t redirect_pc,
    input  logic           arready,
    output logic           arvalid,
    output ifu_pkg::addr_t araddr,
    input  logic           rvalid,
    output logic           rready,
    input  ifu_pkg::beat_t rdata,
    output logic           inst_valid,
    input  logic           inst_ready,
    output ifu_pkg::inst_t inst,
    output ifu_pkg::addr_t inst_pc,
    output logic           inst_compressed
);

    logic           push;
    logic           pop;
    logic           empty;
    ifu_pkg::beat_t beat;
    ifu_pkg::beat_t head;

    inst_if inst_bus ();

    // queue space is reserved by credits before each address goes out
    assign rready = 1'b1;

    fetch_request #(
        .RST_PC          (RST_PC),
        .FIFO_DEPTH      (FIFO_DEPTH),
        .MAX_OUTSTANDING (MAX_OUTSTANDING)
    ) u_fetch_request (
        .clk            (clk),
        .rst_n          (rst_n),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .arready        (arready),
        .rvalid         (rvalid),
        .rdata          (rdata),
        .pop            (pop),
        .arvalid        (arvalid),
        .araddr         (araddr),
        .push           (push),
        .beat           (beat)
    );

    beat_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_beat_fifo (
        .clk            (clk),
        .rst_n          (rst_n),
        .redirect_valid (redirect_valid),
        .push           (push),
        .beat           (beat),
        .pop            (pop),
        .head           (head),
        .empty          (empty)
    );

    inst_aligner #(
        .RST_PC (RST_PC)
    ) u_inst_aligner (
        .clk            (clk),
        .rst_n          (rst_n),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .head           (head),
        .empty          (empty),
        .pop            (pop),
        .out            (inst_bus.aligner)
    );

    decode_buffer u_decode_buffer (
        .clk             (clk),
        .rst_n           (rst_n),
        .redirect_valid  (redirect_valid),
        .in              (inst_bus.buffer),
        .inst_ready      (inst_ready),
        .inst_valid      (inst_valid),
        .inst            (inst),
        .inst_pc         (inst_pc),
        .inst_compressed (inst_compressed)
    );

endmodule

// ==== verification/tb_clock.sv ====
module tb_clock #(
    parameter int PERIOD = 10
) (
    output logic clk
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
    end

    always #(PERIOD / 2) clk = ~clk;

endmodule

// ==== verification/ifu_chk.sv ====
module ifu_chk import ifu_pkg::*; (
    input logic  clk,
    input logic  rst_n,
    input logic  redirect_valid,
    input logic  arvalid,
    input logic  arready,
    input addr_t araddr,
    input logic  inst_valid,
    input logic  inst_ready,
    input inst_t inst,
    input addr_t inst_pc,
    input logic  inst_compressed,
    input logic  empty
);
    timeunit 1ns;
    timeprecision 100ps;

    // number of assertion failures so far
    int fail_count = 0;

    // a stalled read address holds until accepted
    ar_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (arvalid && !arready && !redirect_valid) |=> (arvalid && $stable(araddr)))
    else begin
        $error("read address dropped or changed while arready was low");
        fail_count++;
    end

    // decode sees the same instruction until it takes it
    inst_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (inst_valid && !inst_ready && !redirect_valid) |=>
        (inst_valid && $stable(inst) && $stable(inst_pc) && $stable(inst_compressed)))
    else begin
        $error("instruction output changed under back-pressure");
        fail_count++;
    end

    redirect_clear: assert property (@(posedge clk) disable iff (!rst_n)
        redirect_valid |=> (!inst_valid && !arvalid && empty))
    else begin
        $error("fetch state not cleared in the cycle after a redirect");
        fail_count++;
    end

endmodule

bind ifu_top ifu_chk u_chk (
    .clk             (clk),
    .rst_n           (rst_n),
    .redirect_valid  (redirect_valid),
    .arvalid         (arvalid),
    .arready         (arready),
    .araddr          (araddr),
    .inst_valid      (inst_valid),
    .inst_ready      (inst_ready),
    .inst            (inst),
    .inst_pc         (inst_pc),
    .inst_compressed (inst_compressed),
    .empty           (empty)
);

// ==== verification/tb_ifu.sv ====
module tb_ifu import ifu_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam addr_t RST_PC       = 64'h1000;
    localparam int    CLK_PERIOD   = 10;
    localparam int    STALL_CYCLES = 60;
    // instructions taken over all tests, and a generous bound for each
    localparam int    INST_TOTAL   = 40 + 12 + 26 + 60 + 40;
    localparam int    INST_CYCLES  = 25;
    localparam int    LIMIT_CYCLES = INST_TOTAL * INST_CYCLES + STALL_CYCLES + 300;
    // halfwords starting a 32-bit op, indexed by addr[4:1]
    localparam logic [15:0] LONG_MASK = 16'h498A;

    logic  clk;
    logic  rst_n;
    logic  redirect_valid;
    addr_t redirect_pc;
    logic  arready;
    logic  arvalid;
    addr_t araddr;
    logic  rvalid;
    logic  rready;
    beat_t rdata;
    logic  inst_valid;
    logic  inst_ready;
    inst_t inst;
    addr_t inst_pc;
    logic  inst_compressed;

    integer seed       = 11;
    int     cycle      = 0;
    // 0 always ready, 1 random, 2 held low
    int     ready_mode = 0;
    addr_t  pend_addr[$];
    int     pend_due[$];

    tb_clock #(.PERIOD(CLK_PERIOD)) u_clock (.clk(clk));

    ifu_top #(
        .RST_PC          (RST_PC),
        .FIFO_DEPTH      (4),
        .MAX_OUTSTANDING (4)
    ) i_dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .redirect_valid  (redirect_valid),
        .redirect_pc     (redirect_pc),
        .arready         (arready),
        .arvalid         (arvalid),
        .araddr          (araddr),
        .rvalid          (rvalid),
        .rready          (rready),
        .rdata           (rdata),
        .inst_valid      (inst_valid),
        .inst_ready      (inst_ready),
        .inst            (inst),
        .inst_pc         (inst_pc),
        .inst_compressed (inst_compressed)
    );

    // program image, upper bits hashed from the whole address
    function automatic half_t half_at(addr_t a);
        addr_t mix;
        mix = a ^ (a >> 14) ^ (a >> 28) ^ (a >> 42) ^ (a >> 56);
        return {mix[14:1], LONG_MASK[a[4:1]] ? 2'b11 : (a[1] ? 2'b10 : 2'b01)};
    endfunction

    function automatic beat_t beat_at(addr_t a);
        return {half_at(a + 6), half_at(a + 4), half_at(a + 2), half_at(a)};
    endfunction

    // walk one instruction of the image
    task automatic model_next(inout addr_t pc, output inst_t word, output logic comp);
        half_t lo;
        lo   = half_at(pc);
        comp = (lo[1:0] != 2'b11);
        word = comp ? {16'h0000, lo} : {half_at(pc + 2), lo};
        pc   = pc + (comp ? 2 : 4);
    endtask

    task automatic stop_run();
        $display("test failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_pc(input string name, input addr_t exp, input addr_t act);
        if (exp !== act) begin
            $display("MISMATCH %s pc expected %h actual %h", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_inst(input string name, input inst_t exp, input inst_t act);
        if (exp !== act) begin
            $display("MISMATCH %s inst expected %h actual %h", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("MISMATCH %s expected %b actual %b", name, exp, act);
            stop_run();
        end
    endtask

    // memory side: beats in order after a random latency
    always begin
        @(posedge clk);
        cycle++;
        #1;
        rvalid = 1'b0;
        if (pend_addr.size() > 0 && pend_due[0] <= cycle) begin
            rvalid = 1'b1;
            rdata  = beat_at(pend_addr.pop_front());
            void'(pend_due.pop_front());
        end
        arready = (($random(seed) & 3) != 0);
        case (ready_mode)
            0:       inst_ready = 1'b1;
            1:       inst_ready = (($random(seed) & 1) != 0);
            default: inst_ready = 1'b0;
        endcase
    end

    // address handshake seen mid cycle, taken at the next edge
    always @(negedge clk) begin
        if (rst_n && arvalid && arready) begin
            pend_addr.push_back(araddr);
            pend_due.push_back(cycle + 1 + ($random(seed) & 3));
        end
    end

    task automatic take_inst(output addr_t pc, output inst_t word, output logic comp);
        do begin
            @(negedge clk);
        end while (!(inst_valid && inst_ready));
        pc   = inst_pc;
        word = inst;
        comp = inst_compressed;
    endtask

    task automatic expect_stream(input string name, inout addr_t pc, input int count);
        addr_t got_pc;
        inst_t got_inst;
        logic  got_comp;
        addr_t exp_pc;
        inst_t exp_inst;
        logic  exp_comp;
        for (int i = 0; i < count; i++) begin
            take_inst(got_pc, got_inst, got_comp);
            exp_pc = pc;
            model_next(pc, exp_inst, exp_comp);
            check_pc(name, exp_pc, got_pc);
            check_inst(name, exp_inst, got_inst);
            check_flag({name, " compressed"}, exp_comp, got_comp);
            check_flag({name, " rready"}, 1'b1, rready);
        end
    endtask

    task automatic redirect_to(input string name, input addr_t target);
        @(posedge clk);
        #1;
        redirect_valid = 1'b1;
        redirect_pc    = target;
        @(posedge clk);
        #1;
        redirect_valid = 1'b0;
        @(negedge clk);
        check_flag({name, " inst_valid after redirect"}, 1'b0, inst_valid);
        check_flag({name, " arvalid after redirect"}, 1'b0, arvalid);
    endtask

    task automatic test_sequential();
        addr_t pc;
        pc = RST_PC;
        expect_stream("sequential", pc, 40);
    endtask

    // lane3 start, low half in one beat and high half in the next
    task automatic test_cross_beat();
        addr_t pc;
        pc = 64'h2006;
        redirect_to("cross_beat", pc);
        expect_stream("cross_beat", pc, 12);
    endtask

    task automatic test_redirect_outstanding();
        addr_t pc;
        int    waited;
        pc = 64'h3000;
        redirect_to("redirect", pc);
        expect_stream("redirect", pc, 6);
        waited = 0;
        // with two reads queued, at least one beat lands after the redirect
        do begin
            @(negedge clk);
            #1;
            waited++;
        end while (pend_addr.size() < 2 && waited < 100);
        if (pend_addr.size() < 2) begin
            $display("fewer than two reads were outstanding when the redirect was due");
            stop_run();
        end
        pc = 64'h501E;
        redirect_to("redirect", pc);
        expect_stream("redirect", pc, 20);
    endtask

    task automatic test_backpressure();
        addr_t pc;
        pc = 64'h6002;
        redirect_to("backpressure", pc);
        ready_mode = 1;
        expect_stream("backpressure", pc, 60);
        ready_mode = 0;
    endtask

    task automatic test_credit_stall();
        addr_t pc;
        int    last_high;
        pc = 64'h7000;
        redirect_to("credit_stall", pc);
        expect_stream("credit_stall", pc, 10);
        ready_mode = 2;
        last_high  = -1;
        for (int i = 0; i < STALL_CYCLES; i++) begin
            @(negedge clk);
            if (arvalid) begin
                last_high = i;
            end
        end
        // credits must be exhausted well before the stall ends
        if (last_high >= STALL_CYCLES - 20) begin
            $display("arvalid still high at stall cycle %0d, credits never ran out", last_high);
            stop_run();
        end
        ready_mode = 0;
        expect_stream("credit_stall", pc, 30);
    endtask

    initial begin
        rst_n          = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        arready        = 1'b0;
        rvalid         = 1'b0;
        rdata          = '0;
        inst_ready     = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        test_sequential();
        test_cross_beat();
        test_redirect_outstanding();
        test_backpressure();
        test_credit_stall();
        if (i_dut.u_chk.fail_count == 0) begin
            $display("test passed");
            $finish;
        end else begin
            $display("test failed");
            $fatal(1, "protocol checker reported errors");
        end
    end

    // first assertion failure ends the run
    initial begin
        wait (i_dut.u_chk.fail_count != 0);
        $display("a bound protocol assertion reported an error");
        $display("test failed");
        $fatal(1, "protocol assertion error");
    end

    initial begin
        #(LIMIT_CYCLES * CLK_PERIOD);
        $display("timeout, tests did not complete within %0d cycles", LIMIT_CYCLES);
        $display("test failed");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== ifu.f ====
hw/ifu_pkg.sv
hw/inst_if.sv
hw/fetch_request.sv
hw/beat_fifo.sv
hw/inst_aligner.sv
hw/decode_buffer.sv
hw/ifu_top.sv
verification/tb_clock.sv
verification/ifu_chk.sv
verification/tb_ifu.sv
